//--- design/hps_link_pkg.sv
// hps_link shared types: host bus, command codes, key event, config word and PS/2 TX states
package hps_link_pkg;

	// one word on the host link
	typedef logic [15:0] io_word_t;

	// first word of a transaction
	typedef enum logic [15:0] {
		CMD_CFG     = 16'h0001,
		CMD_JOY0    = 16'h0002,
		CMD_JOY1    = 16'h0003,
		CMD_PS2_KBD = 16'h0005,
		CMD_JOY_RAW = 16'h000f,
		CMD_STATUS  = 16'h001e
	} host_cmd_e;

	// what the host drives, enable frames a transaction
	typedef struct packed {
		logic     enable;
		logic     strobe;
		io_word_t din;
	} host_bus_t;

	// keyboard event word, toggle flips on every event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// config word as the host sends it
	typedef struct packed {
		logic [4:0] rsvd_15_11;
		logic       direct_video;
		logic [4:0] rsvd_9_5;
		logic       forced_scandoubler;
		logic [1:0] rsvd_3_2;
		logic [1:0] buttons;
	} cfg_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} ps2_tx_state_e;

	// scancode prefixes and the host's skip marker
	localparam logic [7:0] KEY_BREAK_PREFIX = 8'hF0;
	localparam logic [7:0] KEY_EXT_PREFIX   = 8'hE0;
	localparam logic [7:0] SKIP_MARK        = 8'hFF;

endpackage

//--- design/hps_cmd_decoder.sv
// host command decoder: config, joystick and status registers, key events and scancode pushes
`timescale 1ns/1ps

module hps_cmd_decoder (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  hps_link_pkg::host_bus_t host,
	input  hps_link_pkg::io_word_t  joy_raw,
	output hps_link_pkg::io_word_t  io_dout,
	output hps_link_pkg::cfg_t      cfg,
	output logic [31:0]             joystick_0,
	output logic [31:0]             joystick_1,
	output logic [63:0]             status,
	output hps_link_pkg::ps2_key_t  ps2_key,
	output logic                    push,
	output logic [7:0]              push_data
);

	hps_link_pkg::io_word_t cmd_q;
	// 0 while waiting for the command word, saturates at 7
	logic [2:0]  arg_cnt;
	logic        skip;
	logic [31:0] key_raw;

	logic word_stb;
	logic arg_stb;
	logic kbd_stb;
	logic din_is_skip;
	logic key_pressed;
	logic key_extended;

	assign word_stb    = host.enable && host.strobe;
	assign arg_stb     = word_stb && (arg_cnt != 3'd0);
	assign kbd_stb     = arg_stb && (cmd_q == hps_link_pkg::CMD_PS2_KBD);
	assign din_is_skip = (host.din[15:8] == hps_link_pkg::SKIP_MARK);

	// release has F0 just before the code, E0 sits one byte further back then
	assign key_pressed  = (key_raw[15:8] != hps_link_pkg::KEY_BREAK_PREFIX);
	assign key_extended = key_pressed ? (key_raw[15:8] == hps_link_pkg::KEY_EXT_PREFIX)
	                                  : (key_raw[23:16] == hps_link_pkg::KEY_EXT_PREFIX);

	//////////////////////////////////////////////////////////////
	// transaction tracking and register writes
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd_q      <= '0;
			arg_cnt    <= '0;
			skip       <= 1'b0;
			io_dout    <= '0;
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			ps2_key    <= '0;
			push       <= 1'b0;
		end else begin
			push <= 1'b0;
			if (!host.enable) begin
				// end of transaction, publish the key event once
				if (cmd_q == hps_link_pkg::CMD_PS2_KBD && !skip) begin
					ps2_key.toggle   <= ~ps2_key.toggle;
					ps2_key.pressed  <= key_pressed;
					ps2_key.extended <= key_extended;
					ps2_key.code     <= key_raw[7:0];
				end
				cmd_q   <= '0;
				arg_cnt <= '0;
				skip    <= 1'b0;
				io_dout <= '0;
			end else if (host.strobe) begin
				io_dout <= '0;
				if (arg_cnt != 3'd7) begin
					arg_cnt <= arg_cnt + 3'd1;
				end
				if (arg_cnt == 3'd0) begin
					cmd_q <= host.din;
				end else begin
					case (cmd_q)
						hps_link_pkg::CMD_CFG: begin
							cfg <= host.din;
						end
						hps_link_pkg::CMD_JOY0: begin
							if (arg_cnt == 3'd1) begin
								joystick_0[15:0] <= host.din;
							end else if (arg_cnt == 3'd2) begin
								joystick_0[31:16] <= host.din;
							end
						end
						hps_link_pkg::CMD_JOY1: begin
							if (arg_cnt == 3'd1) begin
								joystick_1[15:0] <= host.din;
							end else if (arg_cnt == 3'd2) begin
								joystick_1[31:16] <= host.din;
							end
						end
						hps_link_pkg::CMD_STATUS: begin
							// low quarter first, anything past the fourth word is dropped
							case (arg_cnt)
								3'd1: status[15:0]  <= host.din;
								3'd2: status[31:16] <= host.din;
								3'd3: status[47:32] <= host.din;
								3'd4: status[63:48] <= host.din;
								default: ;
							endcase
						end
						hps_link_pkg::CMD_JOY_RAW: begin
							io_dout <= joy_raw;
						end
						hps_link_pkg::CMD_PS2_KBD: begin
							if (din_is_skip) begin
								skip <= 1'b1;
							end
							// every byte goes to the serializer, skip or not
							push <= 1'b1;
						end
						default: ;
					endcase
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// scancode history and FIFO data
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (word_stb && arg_cnt == 3'd0 && host.din == hps_link_pkg::CMD_PS2_KBD) begin
			key_raw <= '0;
		end else if (kbd_stb && !din_is_skip && !skip) begin
			key_raw <= {key_raw[23:0], host.din[7:0]};
		end
		if (kbd_stb) begin
			push_data <= host.din[7:0];
		end
	end

	// a push always follows a keyboard argument strobe of the same transaction
	a_push_in_kbd_cmd: assert property (@(posedge clk_sys) disable iff (!arst_n)
		push |-> $past(word_stb) && (cmd_q == hps_link_pkg::CMD_PS2_KBD));

endmodule

//--- design/ps2_tx_fifo.sv
// scancode byte FIFO between the command decoder and the PS/2 serializer
`timescale 1ns/1ps

module ps2_tx_fifo #(
	parameter int FIFO_AW = 4
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       push,
	input  logic [7:0] push_data,
	input  logic       pop,
	output logic [7:0] pop_data,
	output logic       empty,
	output logic       full
);

	localparam int DEPTH = 1 << FIFO_AW;

	logic [7:0] mem [DEPTH];

	// extra msb tells a full buffer from an empty one
	logic [FIFO_AW:0] wr_ptr;
	logic [FIFO_AW:0] rd_ptr;

	assign empty    = (wr_ptr == rd_ptr);
	assign full     = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
	                  (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
	assign pop_data = mem[rd_ptr[FIFO_AW-1:0]];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push && !full) begin
			mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
		end
	end

	a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (!arst_n)
		pop |-> !empty);

	// occupancy stays within the buffer across any push and pop mix
	a_ptr_span: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(wr_ptr - rd_ptr) <= (FIFO_AW + 1)'(DEPTH));

endmodule

//--- design/ps2_kbd_serializer.sv
// PS/2 keyboard transmitter: bit clock divider, line idle check and frame shifter
`timescale 1ns/1ps

module ps2_kbd_serializer #(
	parameter int PS2_DIV = 4
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       empty,
	output logic       pop,
	input  logic [7:0] pop_data,
	input  logic       ps2_kbd_clk_in,
	input  logic       ps2_kbd_data_in,
	output logic       ps2_kbd_clk_out,
	output logic       ps2_kbd_data_out
);

	localparam int         DIV_W      = $clog2(PS2_DIV + 1);
	localparam logic [2:0] IDLE_TICKS = 3'd4;

	logic [DIV_W-1:0] div_cnt;
	logic             ps2_phase;
	logic             div_wrap;
	logic             rise_tick;
	logic             fall_tick;

	logic [1:0] clk_sync;
	logic [1:0] dat_sync;
	logic       lines_idle;
	logic [2:0] idle_cnt;

	hps_link_pkg::ps2_tx_state_e state;
	logic [7:0] shift;
	logic [2:0] bit_cnt;
	logic       parity;

	//////////////////////////////////////////////////////////////
	// PS/2 clock divider, one tick per half period
	//////////////////////////////////////////////////////////////

	assign div_wrap  = (div_cnt == DIV_W'(PS2_DIV - 1));
	assign rise_tick = div_wrap && !ps2_phase;
	assign fall_tick = div_wrap && ps2_phase;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt   <= '0;
			ps2_phase <= 1'b0;
		end else if (div_wrap) begin
			div_cnt   <= '0;
			ps2_phase <= ~ps2_phase;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// line inputs come from the host machine's domain
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
		end else begin
			clk_sync <= {clk_sync[0], ps2_kbd_clk_in};
			dat_sync <= {dat_sync[0], ps2_kbd_data_in};
		end
	end

	assign lines_idle = clk_sync[1] && dat_sync[1];

	// start a frame only after the lines were released for a while
	assign pop = rise_tick && (state == hps_link_pkg::TX_IDLE) && !empty &&
	             lines_idle && (idle_cnt == IDLE_TICKS);

	//////////////////////////////////////////////////////////////
	// frame FSM, data changes on rising ticks
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state            <= hps_link_pkg::TX_IDLE;
			idle_cnt         <= '0;
			bit_cnt          <= '0;
			parity           <= 1'b1;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else begin
			if (fall_tick && state != hps_link_pkg::TX_IDLE) begin
				ps2_kbd_clk_out <= 1'b0;
			end
			if (rise_tick) begin
				ps2_kbd_clk_out <= 1'b1;
				if (!lines_idle) begin
					idle_cnt <= '0;
				end else if (idle_cnt != IDLE_TICKS) begin
					idle_cnt <= idle_cnt + 3'd1;
				end
				case (state)
					hps_link_pkg::TX_IDLE: begin
						if (pop) begin
							idle_cnt         <= '0;
							parity           <= 1'b1;
							ps2_kbd_data_out <= 1'b0;
							state            <= hps_link_pkg::TX_START;
						end
					end
					hps_link_pkg::TX_START: begin
						ps2_kbd_data_out <= shift[0];
						parity           <= parity ^ shift[0];
						bit_cnt          <= '0;
						state            <= hps_link_pkg::TX_DATA;
					end
					hps_link_pkg::TX_DATA: begin
						if (bit_cnt == 3'd7) begin
							ps2_kbd_data_out <= parity;
							state            <= hps_link_pkg::TX_PARITY;
						end else begin
							ps2_kbd_data_out <= shift[0];
							parity           <= parity ^ shift[0];
							bit_cnt          <= bit_cnt + 3'd1;
						end
					end
					hps_link_pkg::TX_PARITY: begin
						ps2_kbd_data_out <= 1'b1;
						state            <= hps_link_pkg::TX_STOP;
					end
					default: begin
						state <= hps_link_pkg::TX_IDLE;
					end
				endcase
			end
		end
	end

	// byte shifter, lsb goes out first
	always_ff @(posedge clk_sys) begin
		if (pop) begin
			shift <= pop_data;
		end else if (rise_tick && (state == hps_link_pkg::TX_START ||
		                           state == hps_link_pkg::TX_DATA)) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

	a_clk_low_in_frame: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!ps2_kbd_clk_out |-> state != hps_link_pkg::TX_IDLE);

endmodule

//--- design/hps_link.sv
// hps_link top level: host command link with registers, key events and PS/2 keyboard output
`timescale 1ns/1ps

module hps_link #(
	parameter int PS2_DIV = 4,
	parameter int FIFO_AW = 4
) (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  hps_link_pkg::host_bus_t host,
	output hps_link_pkg::io_word_t  io_dout,
	input  hps_link_pkg::io_word_t  joy_raw,
	output logic [31:0]             joystick_0,
	output logic [31:0]             joystick_1,
	output logic [63:0]             status,
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic                    direct_video,
	output hps_link_pkg::ps2_key_t  ps2_key,
	output logic                    ps2_kbd_clk_out,
	output logic                    ps2_kbd_data_out,
	input  logic                    ps2_kbd_clk_in,
	input  logic                    ps2_kbd_data_in
);

	hps_link_pkg::cfg_t cfg;
	logic       push;
	logic [7:0] push_data;
	logic       pop;
	logic [7:0] pop_data;
	logic       empty;

	assign buttons            = cfg.buttons;
	assign forced_scandoubler = cfg.forced_scandoubler;
	assign direct_video       = cfg.direct_video;

	hps_cmd_decoder u_decoder (
		.clk_sys, .arst_n, .host, .joy_raw, .io_dout, .cfg,
		.joystick_0, .joystick_1, .status, .ps2_key, .push, .push_data
	);

	// full only matters inside the FIFO, where it drops pushes
	ps2_tx_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
		.clk_sys, .arst_n, .push, .push_data, .pop, .pop_data, .empty, .full()
	);

	ps2_kbd_serializer #(.PS2_DIV(PS2_DIV)) u_serializer (
		.clk_sys, .arst_n, .empty, .pop, .pop_data,
		.ps2_kbd_clk_in, .ps2_kbd_data_in, .ps2_kbd_clk_out, .ps2_kbd_data_out
	);

endmodule

//--- dv/hps_link_tb.sv
// hps_link testbench: directed host transactions, key event model and PS/2 frame monitor
`timescale 1ns/1ps

module hps_link_tb;

	localparam int PS2_DIV   = 4;
	localparam int FIFO_AW   = 4;
	localparam int FRAMES    = 13;
	localparam int FRAME_CYC = 11 * 2 * PS2_DIV;
	localparam int HOLD_CYC  = 3 * FRAME_CYC;
	// all frames on the line, the inhibit hold, and room for host transactions
	localparam int WATCHDOG_NS = FRAMES * FRAME_CYC * 20 + HOLD_CYC * 20 + 30000;

	logic                    clk_sys;
	logic                    arst_n;
	hps_link_pkg::host_bus_t host;
	hps_link_pkg::io_word_t  io_dout;
	hps_link_pkg::io_word_t  joy_raw;
	logic [31:0]             joystick_0;
	logic [31:0]             joystick_1;
	logic [63:0]             status;
	logic [1:0]              buttons;
	logic                    forced_scandoubler;
	logic                    direct_video;
	hps_link_pkg::ps2_key_t  ps2_key;
	logic                    ps2_kbd_clk_out;
	logic                    ps2_kbd_data_out;
	logic                    ps2_kbd_clk_in;
	logic                    ps2_kbd_data_in;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_start_err = 0;
	logic [31:0] lfsr_state = 32'h0455_d52f;
	hps_link_pkg::ps2_key_t exp_key = '0;
	logic [7:0] exp_bytes[$];
	logic [7:0] rx_bytes[$];
	int fall_count = 0;
	int bit_idx = 0;
	logic [10:0] frame;

	hps_link #(.PS2_DIV(PS2_DIV), .FIFO_AW(FIFO_AW)) UUT (
		.clk_sys, .arst_n, .host, .io_dout, .joy_raw, .joystick_0, .joystick_1, .status,
		.buttons, .forced_scandoubler, .direct_video, .ps2_key, .ps2_kbd_clk_out,
		.ps2_kbd_data_out, .ps2_kbd_clk_in, .ps2_kbd_data_in
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == test_start_err) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - test_start_err);
		end
		test_start_err = errors;
	endtask

	task automatic open_xfer();
		@(negedge clk_sys);
		host.enable = 1'b1;
	endtask

	// one strobe, then idle cycles during which the reply holds
	task automatic send_word(input logic [15:0] w);
		@(negedge clk_sys);
		host.strobe = 1'b1;
		host.din    = w;
		@(negedge clk_sys);
		host.strobe = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic close_xfer();
		@(negedge clk_sys);
		host.enable = 1'b0;
		host.din    = '0;
		repeat (2) @(negedge clk_sys);
	endtask

	// sends n scancode words and predicts the key event from the bytes kept
	task automatic send_keys(input logic [47:0] words, input int n);
		logic [7:0]  kept[$];
		logic        skipped;
		logic [15:0] w;
		logic [7:0]  before_code;
		logic [7:0]  two_before;
		int          last;
		skipped = 1'b0;
		open_xfer();
		send_word(hps_link_pkg::CMD_PS2_KBD);
		for (int i = 0; i < n; i++) begin
			w = words[16*i +: 16];
			exp_bytes.push_back(w[7:0]);
			if (w[15:8] == hps_link_pkg::SKIP_MARK) begin
				skipped = 1'b1;
			end else if (!skipped) begin
				kept.push_back(w[7:0]);
			end
			send_word(w);
		end
		close_xfer();
		if (!skipped) begin
			last        = kept.size() - 1;
			before_code = 8'h00;
			two_before  = 8'h00;
			if (last >= 1) begin
				before_code = kept[last-1];
			end
			if (last >= 2) begin
				two_before = kept[last-2];
			end
			exp_key.toggle = ~exp_key.toggle;
			exp_key.code   = kept[last];
			// a release carries F0 right before the code
			if (before_code == hps_link_pkg::KEY_BREAK_PREFIX) begin
				exp_key.pressed  = 1'b0;
				exp_key.extended = (two_before == hps_link_pkg::KEY_EXT_PREFIX);
			end else begin
				exp_key.pressed  = 1'b1;
				exp_key.extended = (before_code == hps_link_pkg::KEY_EXT_PREFIX);
			end
		end
		check_value("ps2_key", ps2_key, exp_key);
	endtask

	task automatic wait_rx(input int n);
		int cyc;
		cyc = 0;
		while (rx_bytes.size() < n && cyc < (n + 1) * 2 * FRAME_CYC) begin
			@(negedge clk_sys);
			cyc++;
		end
		assert (rx_bytes.size() >= n) else begin
			$display("timed out waiting for PS/2 frame %0d, only %0d arrived", n, rx_bytes.size());
			errors++;
		end
	endtask

	task automatic compare_rx(input int first, input int last);
		for (int i = first; i < last && i < rx_bytes.size(); i++) begin
			check_value("ps2 frame byte", rx_bytes[i], exp_bytes[i]);
		end
	endtask

	// receiver view, data sampled on each falling edge of the PS/2 clock
	always @(negedge ps2_kbd_clk_out) begin
		if (arst_n) begin
			fall_count++;
			frame[bit_idx] = ps2_kbd_data_out;
			if (bit_idx == 10) begin
				check_value("ps2 start bit", frame[0], 1'b0);
				check_value("ps2 odd parity", ^frame[9:1], 1'b1);
				check_value("ps2 stop bit", frame[10], 1'b1);
				rx_bytes.push_back(frame[8:1]);
				bit_idx = 0;
			end else begin
				bit_idx++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_state();
		check_value("io_dout", io_dout, 16'h0);
		check_value("ps2_key", ps2_key, '0);
		check_value("ps2_kbd_clk_out", ps2_kbd_clk_out, 1'b1);
		check_value("ps2_kbd_data_out", ps2_kbd_data_out, 1'b1);
		report_test("reset");
	endtask

	task automatic config_regs();
		logic [15:0] w;
		w = 16'(rand_bits(16));
		open_xfer();
		send_word(hps_link_pkg::CMD_CFG);
		send_word(w);
		close_xfer();
		check_value("buttons", buttons, w[1:0]);
		check_value("forced_scandoubler", forced_scandoubler, w[4]);
		check_value("direct_video", direct_video, w[10]);
		report_test("config");
	endtask

	task automatic joystick_words();
		logic [15:0] lo;
		logic [15:0] hi;
		logic [31:0] j0;
		lo = 16'(rand_bits(16));
		hi = 16'(rand_bits(16));
		j0 = {hi, lo};
		open_xfer();
		send_word(hps_link_pkg::CMD_JOY0);
		send_word(lo);
		send_word(hi);
		close_xfer();
		check_value("joystick_0", joystick_0, j0);
		check_value("joystick_1", joystick_1, 32'h0);
		lo = 16'(rand_bits(16));
		hi = 16'(rand_bits(16));
		open_xfer();
		send_word(hps_link_pkg::CMD_JOY1);
		send_word(lo);
		send_word(hi);
		close_xfer();
		check_value("joystick_1", joystick_1, {hi, lo});
		check_value("joystick_0", joystick_0, j0);
		report_test("joysticks");
	endtask

	task automatic status_word();
		logic [15:0] w [5];
		for (int i = 0; i < 5; i++) begin
			w[i] = 16'(rand_bits(16));
		end
		open_xfer();
		send_word(hps_link_pkg::CMD_STATUS);
		for (int i = 0; i < 5; i++) begin
			send_word(w[i]);
		end
		close_xfer();
		// fifth word must be ignored
		check_value("status", status, {w[3], w[2], w[1], w[0]});
		report_test("status");
	endtask

	task automatic raw_readback();
		logic [15:0] raw;
		open_xfer();
		send_word(hps_link_pkg::CMD_JOY_RAW);
		// the command word itself asks for nothing
		check_value("io_dout", io_dout, 16'h0);
		for (int i = 0; i < 3; i++) begin
			// new input value per argument, each strobe picks up the current one
			raw     = 16'(rand_bits(16));
			joy_raw = raw;
			send_word(16'(rand_bits(16)));
			check_value("io_dout", io_dout, raw);
		end
		close_xfer();
		check_value("io_dout", io_dout, 16'h0);
		report_test("raw readback");
	endtask

	task automatic key_events();
		logic [7:0] rc;
		// below 0x80 so the code never looks like a prefix
		rc = {1'b0, 7'(rand_bits(7))};
		send_keys({32'h0, 8'h00, rc}, 1);
		send_keys({16'h0, 8'h00, rc, 8'h00, hps_link_pkg::KEY_BREAK_PREFIX}, 2);
		send_keys({16'h0, 16'h0075, 8'h00, hps_link_pkg::KEY_EXT_PREFIX}, 2);
		send_keys({16'h0075, 8'h00, hps_link_pkg::KEY_BREAK_PREFIX,
		           8'h00, hps_link_pkg::KEY_EXT_PREFIX}, 3);
		send_keys({16'h0033, hps_link_pkg::SKIP_MARK, 8'h22, 16'h0011}, 3);
		report_test("key events");
	endtask

	task automatic serial_frames();
		int sent;
		int falls;
		sent = exp_bytes.size();
		wait_rx(sent);
		compare_rx(0, sent);
		// host machine inhibits the keyboard
		@(negedge clk_sys);
		ps2_kbd_clk_in = 1'b0;
		falls = fall_count;
		send_keys({16'h0, 16'h006b, 8'h00, hps_link_pkg::KEY_EXT_PREFIX}, 2);
		repeat (HOLD_CYC) @(negedge clk_sys);
		check_value("ps2 clock edges while inhibited", fall_count, falls);
		check_value("ps2_kbd_clk_out", ps2_kbd_clk_out, 1'b1);
		ps2_kbd_clk_in = 1'b1;
		wait_rx(exp_bytes.size());
		compare_rx(sent, exp_bytes.size());
		report_test("serial frames");
	endtask

	initial begin
		host            = '0;
		joy_raw         = '0;
		ps2_kbd_clk_in  = 1'b1;
		ps2_kbd_data_in = 1'b1;
		arst_n          = 1'b0;
		repeat (16) @(negedge clk_sys);
		arst_n = 1'b1;
		reset_state();
		config_regs();
		joystick_words();
		status_word();
		raw_readback();
		key_events();
		serial_frames();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- hps_link.f
design/hps_link_pkg.sv
design/hps_cmd_decoder.sv
design/ps2_tx_fifo.sv
design/ps2_kbd_serializer.sv
design/hps_link.sv
dv/hps_link_tb.sv

//--- Bender.yml
package:
  name: hps_link

sources:
  - files:
      - design/hps_link_pkg.sv
      - design/hps_cmd_decoder.sv
      - design/ps2_tx_fifo.sv
      - design/ps2_kbd_serializer.sv
      - design/hps_link.sv
  - target: simulation
    files:
      - dv/hps_link_tb.sv
